//--- hdl/mc_bridge_pkg.sv
package mc_bridge_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int PADDR_WIDTH     = 40;
  localparam int DATA_WIDTH      = 32;
  localparam int MASK_WIDTH      = DATA_WIDTH / 8;
  localparam int MC_ADDR_WIDTH   = 18;
  localparam int X_CORD_WIDTH    = 7;
  localparam int Y_CORD_WIDTH    = 7;
  localparam int POD_Y_WIDTH     = 4;
  localparam int Y_SUBCORD_WIDTH = 3;
  localparam int BYTE_OFS_WIDTH  = 2;
  localparam int REGION_WIDTH    = 2;

  // word addresses inside a tile and inside a vcache
  localparam int TILE_EPA_WIDTH   = 18;
  localparam int VCACHE_EPA_WIDTH = 16;

  // unused bits between the coordinates and the region select
  localparam int TILE_PAD_WIDTH = PADDR_WIDTH - REGION_WIDTH - Y_CORD_WIDTH
                                  - X_CORD_WIDTH - TILE_EPA_WIDTH - BYTE_OFS_WIDTH;
  localparam int VC_PAD_WIDTH   = PADDR_WIDTH - REGION_WIDTH - (POD_Y_WIDTH - 1)
                                  - X_CORD_WIDTH - VCACHE_EPA_WIDTH - BYTE_OFS_WIDTH;

  ////////////////////////////////////////////////////////////////////////////
  // queue and tracker sizing
  ////////////////////////////////////////////////////////////////////////////
  localparam int MAX_OUTSTANDING = 4;
  localparam int TRANS_ID_WIDTH  = $clog2(MAX_OUTSTANDING);
  localparam int TRANS_CNT_WIDTH = $clog2(MAX_OUTSTANDING + 1);
  localparam int CMD_FIFO_DEPTH  = 2;
  localparam int CMD_PTR_WIDTH   = (CMD_FIFO_DEPTH > 1) ? $clog2(CMD_FIFO_DEPTH) : 1;
  localparam int CMD_CNT_WIDTH   = $clog2(CMD_FIFO_DEPTH + 1);

  // top address bits
  localparam logic [REGION_WIDTH-1:0] REGION_TILE   = 2'b11;
  localparam logic [REGION_WIDTH-1:0] REGION_VCACHE = 2'b10;

  // load info bits inside the payload of a load
  localparam int LOAD_PART_SEL_LSB = 0;
  localparam int LOAD_HEX_BIT      = 2;
  localparam int LOAD_BYTE_BIT     = 3;

  typedef enum logic {e_msg_rd = 1'b0, e_msg_wr = 1'b1} msg_type_e;
  typedef enum logic [1:0] {e_size_1 = 2'd0, e_size_2 = 2'd1, e_size_4 = 2'd2} msg_size_e;
  typedef enum logic [1:0]
  {
    e_op_load         = 2'd0,
    e_op_store_word   = 2'd1,
    e_op_store_masked = 2'd2
  } mc_op_e;

  // one physical address, read as a tile or as a vcache location
  typedef union packed
  {
    struct packed
    {
      logic [REGION_WIDTH-1:0]   region;
      logic [TILE_PAD_WIDTH-1:0] pad;
      logic [Y_CORD_WIDTH-1:0]   y_cord;
      logic [X_CORD_WIDTH-1:0]   x_cord;
      logic [TILE_EPA_WIDTH-1:0] epa;
      logic [BYTE_OFS_WIDTH-1:0] byte_ofs;
    } tile;
    struct packed
    {
      logic [REGION_WIDTH-1:0]     region;
      logic [VC_PAD_WIDTH-1:0]     pad;
      logic [POD_Y_WIDTH-2:0]      pod_y;
      logic [X_CORD_WIDTH-1:0]     x_cord;
      logic [VCACHE_EPA_WIDTH-1:0] epa;
      logic [BYTE_OFS_WIDTH-1:0]   byte_ofs;
    } vcache;
  } cmd_addr_u;

endpackage

//--- hdl/bridge_if.sv
`timescale 1ns/1ps

// head of the command queue, ready works as a yumi
interface cmd_if
  import mc_bridge_pkg::*;
  ();

  logic                  valid;
  logic                  ready;
  msg_type_e             msg_type;
  msg_size_e             size;
  cmd_addr_u             addr;
  logic [DATA_WIDTH-1:0] data;

  modport source (output valid, msg_type, size, addr, data, input ready);
  modport sink   (input valid, msg_type, size, addr, data, output ready);

endinterface

// request packet plus the header kept for the response
interface mc_req_if
  import mc_bridge_pkg::*;
  ();

  logic                      valid;
  logic                      grant;
  logic [MC_ADDR_WIDTH-1:0]  addr;
  logic [X_CORD_WIDTH-1:0]   x_cord;
  logic [Y_CORD_WIDTH-1:0]   y_cord;
  mc_op_e                    op;
  logic [MASK_WIDTH-1:0]     mask;
  logic [DATA_WIDTH-1:0]     payload;
  logic [TRANS_ID_WIDTH-1:0] reg_id;
  msg_type_e                 msg_type;
  msg_size_e                 size;
  cmd_addr_u                 cmd_addr;

  modport source
  (
    output valid, addr, x_cord, y_cord, op, mask, payload, msg_type, size, cmd_addr,
    input  reg_id, grant
  );
  modport sink
  (
    input  valid, addr, x_cord, y_cord, op, mask, payload, msg_type, size, cmd_addr,
    output reg_id, grant
  );

endinterface

//--- hdl/cmd_queue.sv
`timescale 1ns/1ps

module cmd_queue
  import mc_bridge_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  io_cmd_v_i,
  output logic                  io_cmd_ready_o,
  input  msg_type_e             io_cmd_msg_type_i,
  input  msg_size_e             io_cmd_size_i,
  input  cmd_addr_u             io_cmd_addr_i,
  input  logic [DATA_WIDTH-1:0] io_cmd_data_i,
  cmd_if.source                 cmd_o
);

  msg_type_e             type_mem [CMD_FIFO_DEPTH];
  msg_size_e             size_mem [CMD_FIFO_DEPTH];
  cmd_addr_u             addr_mem [CMD_FIFO_DEPTH];
  logic [DATA_WIDTH-1:0] data_mem [CMD_FIFO_DEPTH];

  logic [CMD_PTR_WIDTH-1:0] wptr_r;
  logic [CMD_PTR_WIDTH-1:0] rptr_r;
  logic [CMD_CNT_WIDTH-1:0] count_r;
  logic                     push;
  logic                     pop;

  assign io_cmd_ready_o = (count_r != CMD_CNT_WIDTH'(CMD_FIFO_DEPTH));
  assign push           = io_cmd_v_i & io_cmd_ready_o;
  // consumer only raises ready on a valid head
  assign pop            = cmd_o.ready;

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      type_mem[wptr_r] <= io_cmd_msg_type_i;
      size_mem[wptr_r] <= io_cmd_size_i;
      addr_mem[wptr_r] <= io_cmd_addr_i;
      data_mem[wptr_r] <= io_cmd_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end
    else
    begin
      if (push)
        wptr_r <= (wptr_r == CMD_PTR_WIDTH'(CMD_FIFO_DEPTH - 1)) ? '0 : wptr_r + 1'b1;
      if (pop)
        rptr_r <= (rptr_r == CMD_PTR_WIDTH'(CMD_FIFO_DEPTH - 1)) ? '0 : rptr_r + 1'b1;
      if (push && !pop)
        count_r <= count_r + 1'b1;
      else if (pop && !push)
        count_r <= count_r - 1'b1;
    end
  end

  // head entry
  assign cmd_o.valid    = (count_r != '0);
  assign cmd_o.msg_type = type_mem[rptr_r];
  assign cmd_o.size     = size_mem[rptr_r];
  assign cmd_o.addr     = addr_mem[rptr_r];
  assign cmd_o.data     = data_mem[rptr_r];

endmodule

//--- hdl/packet_encode.sv
`timescale 1ns/1ps

module packet_encode
  import mc_bridge_pkg::*;
(
  cmd_if.sink                     cmd_i,
  mc_req_if.source                req_o,
  input  logic [X_CORD_WIDTH-1:0] my_x_i,
  input  logic [Y_CORD_WIDTH-1:0] my_y_i
);

  cmd_addr_u                   addr;
  logic [REGION_WIDTH-1:0]     region;
  logic [BYTE_OFS_WIDTH-1:0]   byte_ofs;
  logic                        is_tile;
  logic                        is_vcache;
  logic [POD_Y_WIDTH-1:0]      vc_pod_y;
  logic [Y_SUBCORD_WIDTH-1:0]  vc_subcord;
  logic [MASK_WIDTH-1:0]       store_mask;

  assign addr     = cmd_i.addr;
  // region and byte offset sit at the same place in both views
  assign region   = addr.tile.region;
  assign byte_ofs = addr.tile.byte_ofs;

  assign is_tile   = (region == REGION_TILE);
  assign is_vcache = (region == REGION_VCACHE);

  // vcaches live in the even pods only
  assign vc_pod_y   = {addr.vcache.pod_y, 1'b0};
  assign vc_subcord = (vc_pod_y == '0) ? '1 : '0;

  ////////////////////////////////////////////////////////////////////////////
  // destination
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    if (is_tile)
    begin
      req_o.addr   = MC_ADDR_WIDTH'(addr.tile.epa);
      req_o.x_cord = addr.tile.x_cord;
      req_o.y_cord = addr.tile.y_cord;
    end
    else if (is_vcache)
    begin
      req_o.addr   = MC_ADDR_WIDTH'(addr.vcache.epa);
      req_o.x_cord = addr.vcache.x_cord;
      req_o.y_cord = {vc_pod_y, vc_subcord};
    end
    else
    begin
      // host tile sits one row above this link
      req_o.addr   = addr[BYTE_OFS_WIDTH +: MC_ADDR_WIDTH];
      req_o.x_cord = '0;
      req_o.y_cord = my_y_i - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // op, mask and payload
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    case (cmd_i.size)
      e_size_1: store_mask = MASK_WIDTH'(4'h1) << byte_ofs;
      e_size_2: store_mask = MASK_WIDTH'(4'h3) << byte_ofs;
      default:  store_mask = MASK_WIDTH'(4'hf) << byte_ofs;
    endcase
  end

  always_comb
  begin
    req_o.payload = '0;
    if (cmd_i.msg_type == e_msg_rd)
    begin
      req_o.op   = e_op_load;
      req_o.mask = '0;
      // load info tells the target how to shape the returned word
      req_o.payload[LOAD_BYTE_BIT] = (cmd_i.size == e_size_1);
      req_o.payload[LOAD_HEX_BIT]  = (cmd_i.size == e_size_2);
      req_o.payload[LOAD_PART_SEL_LSB +: BYTE_OFS_WIDTH] = byte_ofs;
    end
    else
    begin
      req_o.mask    = store_mask;
      req_o.payload = cmd_i.data;
      req_o.op      = (store_mask == '1) ? e_op_store_word : e_op_store_masked;
    end
  end

  // header rides along for the response
  assign req_o.msg_type = cmd_i.msg_type;
  assign req_o.size     = cmd_i.size;
  assign req_o.cmd_addr = cmd_i.addr;

  assign req_o.valid = cmd_i.valid;
  // head leaves the queue in the cycle the packet goes out
  assign cmd_i.ready = req_o.grant;

endmodule

//--- hdl/reorder_tracker.sv
`timescale 1ns/1ps

module reorder_tracker
  import mc_bridge_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  mc_req_if.sink                    req_i,
  input  logic                      out_ready_i,
  input  logic                      return_v_i,
  input  logic [TRANS_ID_WIDTH-1:0] return_reg_id_i,
  input  logic [DATA_WIDTH-1:0]     return_data_i,
  output logic                      io_resp_v_o,
  input  logic                      io_resp_yumi_i,
  output msg_type_e                 io_resp_msg_type_o,
  output msg_size_e                 io_resp_size_o,
  output cmd_addr_u                 io_resp_addr_o,
  output logic [DATA_WIDTH-1:0]     io_resp_data_o
);

  // saved headers and returned data, indexed by id
  msg_type_e             hdr_type  [MAX_OUTSTANDING];
  msg_size_e             hdr_size  [MAX_OUTSTANDING];
  cmd_addr_u             hdr_addr  [MAX_OUTSTANDING];
  logic [DATA_WIDTH-1:0] resp_data [MAX_OUTSTANDING];

  logic [MAX_OUTSTANDING-1:0] done_r;
  logic [TRANS_ID_WIDTH-1:0]  head_r;
  logic [TRANS_ID_WIDTH-1:0]  tail_r;
  logic [TRANS_CNT_WIDTH-1:0] count_r;
  logic                       id_free;
  logic                       alloc;
  logic                       retire;

  ////////////////////////////////////////////////////////////////////////////
  // allocation
  ////////////////////////////////////////////////////////////////////////////
  assign id_free = (count_r != TRANS_CNT_WIDTH'(MAX_OUTSTANDING));
  assign alloc   = req_i.valid & id_free & out_ready_i;

  assign req_i.grant  = alloc;
  assign req_i.reg_id = tail_r;

  always_ff @(posedge clk_i)
  begin
    if (alloc)
    begin
      hdr_type[tail_r] <= req_i.msg_type;
      hdr_size[tail_r] <= req_i.size;
      hdr_addr[tail_r] <= req_i.cmd_addr;
    end
    // stores come back with no data worth keeping
    if (return_v_i)
    begin
      if (hdr_type[return_reg_id_i] == e_msg_wr)
        resp_data[return_reg_id_i] <= '0;
      else
        resp_data[return_reg_id_i] <= return_data_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // in-order release
  ////////////////////////////////////////////////////////////////////////////
  assign io_resp_v_o = (count_r != '0) & done_r[head_r];
  assign retire      = io_resp_v_o & io_resp_yumi_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      head_r  <= '0;
      tail_r  <= '0;
      count_r <= '0;
      done_r  <= '0;
    end
    else
    begin
      if (alloc)
        tail_r <= (tail_r == TRANS_ID_WIDTH'(MAX_OUTSTANDING - 1)) ? '0 : tail_r + 1'b1;
      if (retire)
        head_r <= (head_r == TRANS_ID_WIDTH'(MAX_OUTSTANDING - 1)) ? '0 : head_r + 1'b1;
      if (alloc && !retire)
        count_r <= count_r + 1'b1;
      else if (retire && !alloc)
        count_r <= count_r - 1'b1;
      // a return never targets the entry that retires in the same cycle
      if (return_v_i)
        done_r[return_reg_id_i] <= 1'b1;
      if (retire)
        done_r[head_r] <= 1'b0;
    end
  end

  // oldest entry, held until yumi
  assign io_resp_msg_type_o = hdr_type[head_r];
  assign io_resp_size_o     = hdr_size[head_r];
  assign io_resp_addr_o     = hdr_addr[head_r];
  assign io_resp_data_o     = resp_data[head_r];

endmodule

//--- hdl/mc_bridge_top.sv
`timescale 1ns/1ps

module mc_bridge_top
  import mc_bridge_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [X_CORD_WIDTH-1:0]   my_x_i,
  input  logic [Y_CORD_WIDTH-1:0]   my_y_i,
  // processor commands
  input  logic                      io_cmd_v_i,
  output logic                      io_cmd_ready_o,
  input  msg_type_e                 io_cmd_msg_type_i,
  input  msg_size_e                 io_cmd_size_i,
  input  cmd_addr_u                 io_cmd_addr_i,
  input  logic [DATA_WIDTH-1:0]     io_cmd_data_i,
  // request packets to the network
  output logic                      out_v_o,
  input  logic                      out_ready_i,
  output logic [MC_ADDR_WIDTH-1:0]  out_addr_o,
  output logic [X_CORD_WIDTH-1:0]   out_x_cord_o,
  output logic [Y_CORD_WIDTH-1:0]   out_y_cord_o,
  output mc_op_e                    out_op_o,
  output logic [MASK_WIDTH-1:0]     out_mask_o,
  output logic [DATA_WIDTH-1:0]     out_payload_o,
  output logic [TRANS_ID_WIDTH-1:0] out_reg_id_o,
  // network returns, always accepted
  input  logic                      return_v_i,
  input  logic [TRANS_ID_WIDTH-1:0] return_reg_id_i,
  input  logic [DATA_WIDTH-1:0]     return_data_i,
  // responses to the processor
  output logic                      io_resp_v_o,
  input  logic                      io_resp_yumi_i,
  output msg_type_e                 io_resp_msg_type_o,
  output msg_size_e                 io_resp_size_o,
  output cmd_addr_u                 io_resp_addr_o,
  output logic [DATA_WIDTH-1:0]     io_resp_data_o
);

  cmd_if    cmd_bus ();
  mc_req_if req_bus ();

  cmd_queue cmd_queue_inst
  (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .io_cmd_v_i        (io_cmd_v_i),
    .io_cmd_ready_o    (io_cmd_ready_o),
    .io_cmd_msg_type_i (io_cmd_msg_type_i),
    .io_cmd_size_i     (io_cmd_size_i),
    .io_cmd_addr_i     (io_cmd_addr_i),
    .io_cmd_data_i     (io_cmd_data_i),
    .cmd_o             (cmd_bus.source)
  );

  packet_encode packet_encode_inst
  (
    .cmd_i  (cmd_bus.sink),
    .req_o  (req_bus.source),
    .my_x_i (my_x_i),
    .my_y_i (my_y_i)
  );

  reorder_tracker reorder_tracker_inst
  (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .req_i              (req_bus.sink),
    .out_ready_i        (out_ready_i),
    .return_v_i         (return_v_i),
    .return_reg_id_i    (return_reg_id_i),
    .return_data_i      (return_data_i),
    .io_resp_v_o        (io_resp_v_o),
    .io_resp_yumi_i     (io_resp_yumi_i),
    .io_resp_msg_type_o (io_resp_msg_type_o),
    .io_resp_size_o     (io_resp_size_o),
    .io_resp_addr_o     (io_resp_addr_o),
    .io_resp_data_o     (io_resp_data_o)
  );

  // outgoing packet straight from the encoder
  assign out_v_o       = req_bus.valid;
  assign out_addr_o    = req_bus.addr;
  assign out_x_cord_o  = req_bus.x_cord;
  assign out_y_cord_o  = req_bus.y_cord;
  assign out_op_o      = req_bus.op;
  assign out_mask_o    = req_bus.mask;
  assign out_payload_o = req_bus.payload;
  assign out_reg_id_o  = req_bus.reg_id;

endmodule

//--- tb/mc_net_model.sv
`timescale 1ns/1ps

// network side, answers every issued id once, in shuffled order
module mc_net_model
  import mc_bridge_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      issue_v_i,
  input  logic [TRANS_ID_WIDTH-1:0] issue_reg_id_i,
  input  logic                      hold_i,
  output logic                      return_v_o,
  output logic [TRANS_ID_WIDTH-1:0] return_reg_id_o,
  output logic [DATA_WIDTH-1:0]     return_data_o
);

  logic [TRANS_ID_WIDTH-1:0] pending [$];
  int                        pick;

  initial
  begin
    return_v_o      = 1'b0;
    return_reg_id_o = '0;
    return_data_o   = '0;
  end

  always @(posedge clk_i)
  begin
    if (rst_n_i && issue_v_i)
      pending.push_back(issue_reg_id_i);
  end

  // random delay, then any pending id may come back
  always @(negedge clk_i)
  begin
    return_v_o = 1'b0;
    if (rst_n_i && !hold_i && (pending.size() > 0) && ($urandom % 3 == 0))
    begin
      pick            = $urandom % pending.size();
      return_v_o      = 1'b1;
      return_reg_id_o = pending[pick];
      return_data_o   = $urandom;
      pending.delete(pick);
    end
  end

endmodule

//--- tb/mc_bridge_assert.sv
`timescale 1ns/1ps

module mc_bridge_assert
  import mc_bridge_pkg::*;
(
  input logic clk_i,
  input logic rst_n_i,
  input logic cmd_v_i,
  input logic cmd_ready_i,
  input logic grant_i,
  input logic out_v_i,
  input logic out_ready_i,
  input logic [MC_ADDR_WIDTH + X_CORD_WIDTH + Y_CORD_WIDTH + $bits(mc_op_e)
               + MASK_WIDTH + DATA_WIDTH + TRANS_ID_WIDTH - 1:0] out_bits_i,
  input logic resp_v_i,
  input logic resp_yumi_i,
  input logic [$bits(msg_type_e) + $bits(msg_size_e) + PADDR_WIDTH
               + DATA_WIDTH - 1:0] resp_bits_i
);

  int   fail_count = 0;
  int   queued;
  int   in_flight;
  logic push;
  logic retire;

  assign push   = cmd_v_i & cmd_ready_i;
  assign retire = resp_v_i & resp_yumi_i;

  // occupancy of the queue and of the id pool
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      queued    <= 0;
      in_flight <= 0;
    end
    else
    begin
      queued    <= queued + int'(push) - int'(grant_i);
      in_flight <= in_flight + int'(grant_i) - int'(retire);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // protocol
  ////////////////////////////////////////////////////////////////////////////
  reset_quiet_a: assert property (@(posedge clk_i)
    (!rst_n_i || $rose(rst_n_i)) |-> (!out_v_i && !resp_v_i))
  else
  begin
    $error("valid raised in or right after reset");
    fail_count++;
  end

  out_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_v_i && !out_ready_i) |=> (out_v_i && $stable(out_bits_i)))
  else
  begin
    $error("packet changed while out_ready_i was low");
    fail_count++;
  end

  resp_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (resp_v_i && !resp_yumi_i) |=> (resp_v_i && $stable(resp_bits_i)))
  else
  begin
    $error("response changed before yumi");
    fail_count++;
  end

  id_limit_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_flight <= MAX_OUTSTANDING)
  else
  begin
    $error("more requests in flight than ids");
    fail_count++;
  end

  queue_full_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (queued == CMD_FIFO_DEPTH) |-> !cmd_ready_i)
  else
  begin
    $error("command accepted into a full queue");
    fail_count++;
  end

endmodule

bind mc_bridge_top mc_bridge_assert mc_bridge_assert_inst
(
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .cmd_v_i     (io_cmd_v_i),
  .cmd_ready_i (io_cmd_ready_o),
  .grant_i     (req_bus.grant),
  .out_v_i     (out_v_o),
  .out_ready_i (out_ready_i),
  .out_bits_i  ({out_addr_o, out_x_cord_o, out_y_cord_o, out_op_o,
                 out_mask_o, out_payload_o, out_reg_id_o}),
  .resp_v_i    (io_resp_v_o),
  .resp_yumi_i (io_resp_yumi_i),
  .resp_bits_i ({io_resp_msg_type_o, io_resp_size_o, io_resp_addr_o, io_resp_data_o})
);

//--- tb/tb_mc_bridge.sv
`timescale 1ns/1ps

module tb_mc_bridge
  import mc_bridge_pkg::*;
();

  localparam int          NUM_CMDS = 64;
  localparam int          TIMEOUT  = 2000;
  localparam logic [31:0] SEED     = 32'h5fe2a986;

  typedef struct packed
  {
    msg_type_e              msg_type;
    msg_size_e              size;
    logic [PADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]  data;
  } cmd_t;

  logic                      clk_i;
  logic                      rst_n_i;
  logic [X_CORD_WIDTH-1:0]   my_x_i;
  logic [Y_CORD_WIDTH-1:0]   my_y_i;
  logic                      io_cmd_v_i;
  logic                      io_cmd_ready_o;
  msg_type_e                 io_cmd_msg_type_i;
  msg_size_e                 io_cmd_size_i;
  cmd_addr_u                 io_cmd_addr_i;
  logic [DATA_WIDTH-1:0]     io_cmd_data_i;
  logic                      out_v_o;
  logic                      out_ready_i;
  logic [MC_ADDR_WIDTH-1:0]  out_addr_o;
  logic [X_CORD_WIDTH-1:0]   out_x_cord_o;
  logic [Y_CORD_WIDTH-1:0]   out_y_cord_o;
  mc_op_e                    out_op_o;
  logic [MASK_WIDTH-1:0]     out_mask_o;
  logic [DATA_WIDTH-1:0]     out_payload_o;
  logic [TRANS_ID_WIDTH-1:0] out_reg_id_o;
  logic                      return_v_i;
  logic [TRANS_ID_WIDTH-1:0] return_reg_id_i;
  logic [DATA_WIDTH-1:0]     return_data_i;
  logic                      io_resp_v_o;
  logic                      io_resp_yumi_i;
  msg_type_e                 io_resp_msg_type_o;
  msg_size_e                 io_resp_size_o;
  cmd_addr_u                 io_resp_addr_o;
  logic [DATA_WIDTH-1:0]     io_resp_data_o;

  // scoreboard state, indexed by command number
  cmd_t                  cmds      [NUM_CMDS];
  logic [DATA_WIDTH-1:0] exp_data  [NUM_CMDS];
  bit                    data_back [NUM_CMDS];
  int                    id_cmd    [MAX_OUTSTANDING];
  int                    n_sent;
  int                    n_issued;
  int                    n_resp;
  logic                  bp_en;
  logic                  hold_returns;
  logic                  id_free;
  logic                  pkt_fire;
  cmd_t                  cmd;

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  mc_bridge_top mc_bridge_top_inst
  (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .my_x_i             (my_x_i),
    .my_y_i             (my_y_i),
    .io_cmd_v_i         (io_cmd_v_i),
    .io_cmd_ready_o     (io_cmd_ready_o),
    .io_cmd_msg_type_i  (io_cmd_msg_type_i),
    .io_cmd_size_i      (io_cmd_size_i),
    .io_cmd_addr_i      (io_cmd_addr_i),
    .io_cmd_data_i      (io_cmd_data_i),
    .out_v_o            (out_v_o),
    .out_ready_i        (out_ready_i),
    .out_addr_o         (out_addr_o),
    .out_x_cord_o       (out_x_cord_o),
    .out_y_cord_o       (out_y_cord_o),
    .out_op_o           (out_op_o),
    .out_mask_o         (out_mask_o),
    .out_payload_o      (out_payload_o),
    .out_reg_id_o       (out_reg_id_o),
    .return_v_i         (return_v_i),
    .return_reg_id_i    (return_reg_id_i),
    .return_data_i      (return_data_i),
    .io_resp_v_o        (io_resp_v_o),
    .io_resp_yumi_i     (io_resp_yumi_i),
    .io_resp_msg_type_o (io_resp_msg_type_o),
    .io_resp_size_o     (io_resp_size_o),
    .io_resp_addr_o     (io_resp_addr_o),
    .io_resp_data_o     (io_resp_data_o)
  );

  // a packet leaves only while an id is free
  assign id_free  = (n_issued - n_resp) < MAX_OUTSTANDING;
  assign pkt_fire = out_v_o && out_ready_i && id_free;

  mc_net_model mc_net_model_inst
  (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .issue_v_i       (pkt_fire),
    .issue_reg_id_i  (out_reg_id_o),
    .hold_i          (hold_returns),
    .return_v_o      (return_v_i),
    .return_reg_id_o (return_reg_id_i),
    .return_data_o   (return_data_i)
  );

  ////////////////////////////////////////////////////////////////////////////
  // reporting and checks
  ////////////////////////////////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    assert (act_v === exp_v)
    else
      abort_run($sformatf("FAIL %s expected %0h actual %0h", name, exp_v, act_v));
  endtask

  // expected packet from the region map and the op rules
  task automatic check_packet(input int idx);
    cmd_t                     c;
    logic [1:0]               ofs;
    logic [3:0]               pod;
    logic [3:0]               base;
    logic [MC_ADDR_WIDTH-1:0] e_addr;
    logic [X_CORD_WIDTH-1:0]  e_x;
    logic [Y_CORD_WIDTH-1:0]  e_y;
    logic [MASK_WIDTH-1:0]    e_mask;
    logic [DATA_WIDTH-1:0]    e_payload;
    mc_op_e                   e_op;
    c   = cmds[idx];
    ofs = c.addr[1:0];
    if (c.addr[39:38] == REGION_TILE)
    begin
      e_addr = c.addr[19:2];
      e_x    = c.addr[26:20];
      e_y    = c.addr[33:27];
    end
    else if (c.addr[39:38] == REGION_VCACHE)
    begin
      pod    = {c.addr[27:25], 1'b0};
      e_addr = {2'b00, c.addr[17:2]};
      e_x    = c.addr[24:18];
      e_y    = {pod, (pod == 4'd0) ? 3'b111 : 3'b000};
    end
    else
    begin
      e_addr = c.addr[19:2];
      e_x    = '0;
      e_y    = my_y_i - 7'd1;
    end
    case (c.size)
      e_size_1: base = 4'h1;
      e_size_2: base = 4'h3;
      default:  base = 4'hf;
    endcase
    if (c.msg_type == e_msg_rd)
    begin
      e_op      = e_op_load;
      e_mask    = '0;
      e_payload = {28'd0, c.size == e_size_1, c.size == e_size_2, ofs};
    end
    else
    begin
      e_mask    = base << ofs;
      e_payload = c.data;
      e_op      = (e_mask == 4'hf) ? e_op_store_word : e_op_store_masked;
    end
    check_value($sformatf("cmd %0d packet addr", idx), e_addr, out_addr_o);
    check_value($sformatf("cmd %0d packet x", idx), e_x, out_x_cord_o);
    check_value($sformatf("cmd %0d packet y", idx), e_y, out_y_cord_o);
    check_value($sformatf("cmd %0d packet op", idx), e_op, out_op_o);
    check_value($sformatf("cmd %0d packet mask", idx), e_mask, out_mask_o);
    check_value($sformatf("cmd %0d packet payload", idx), e_payload, out_payload_o);
    check_value($sformatf("cmd %0d reg_id", idx), idx % MAX_OUTSTANDING, out_reg_id_o);
  endtask

  task automatic check_response(input int idx);
    if (!data_back[idx])
      abort_run($sformatf("response %0d released before its network return", idx));
    check_value($sformatf("resp %0d msg_type", idx), cmds[idx].msg_type, io_resp_msg_type_o);
    check_value($sformatf("resp %0d size", idx), cmds[idx].size, io_resp_size_o);
    check_value($sformatf("resp %0d addr", idx), cmds[idx].addr, io_resp_addr_o);
    check_value($sformatf("resp %0d data", idx), exp_data[idx], io_resp_data_o);
  endtask

  // packets, returns and responses as they cross the clock edge
  always @(posedge clk_i)
  begin
    if (rst_n_i && pkt_fire)
    begin
      if (n_issued >= n_sent)
        abort_run("a packet was issued with no command behind it");
      check_packet(n_issued);
      id_cmd[out_reg_id_o] <= n_issued;
      n_issued             <= n_issued + 1;
    end
    if (rst_n_i && return_v_i)
    begin
      // stores answer with zero data
      if (cmds[id_cmd[return_reg_id_i]].msg_type == e_msg_rd)
        exp_data[id_cmd[return_reg_id_i]] <= return_data_i;
      else
        exp_data[id_cmd[return_reg_id_i]] <= '0;
      data_back[id_cmd[return_reg_id_i]] <= 1'b1;
    end
    if (rst_n_i && io_resp_v_o && io_resp_yumi_i)
    begin
      check_response(n_resp);
      n_resp <= n_resp + 1;
    end
  end

  always @(negedge clk_i)
  begin
    if (mc_bridge_top_inst.mc_bridge_assert_inst.fail_count != 0)
      abort_run("a bound protocol assertion failed");
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////
  // random back-pressure on both handshakes
  always @(negedge clk_i)
  begin
    if (!rst_n_i)
    begin
      out_ready_i    = 1'b0;
      io_resp_yumi_i = 1'b0;
    end
    else
    begin
      out_ready_i    = !bp_en || ($urandom % 4 != 0);
      io_resp_yumi_i = io_resp_v_o && ($urandom % 3 != 0);
    end
  end

  function automatic cmd_t random_cmd(input logic [1:0] region);
    cmd_t c;
    c.msg_type = msg_type_e'($urandom % 2);
    c.size     = msg_size_e'($urandom % 3);
    c.addr     = {region, 6'($urandom), 32'($urandom)};
    c.data     = $urandom;
    return c;
  endfunction

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_cmd(input cmd_t c);
    int waited;
    cmds[n_sent]      = c;
    io_cmd_msg_type_i = c.msg_type;
    io_cmd_size_i     = c.size;
    io_cmd_addr_i     = c.addr;
    io_cmd_data_i     = c.data;
    io_cmd_v_i        = 1'b1;
    waited            = 0;
    while (!io_cmd_ready_o)
    begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT)
        abort_run("timed out waiting for io_cmd_ready_o");
    end
    n_sent++;
    @(negedge clk_i);
    io_cmd_v_i = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (n_resp < n_sent)
    begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT)
        abort_run("timed out waiting for all responses");
    end
  endtask

  task automatic wait_cmd_blocked();
    int waited;
    waited = 0;
    while (io_cmd_ready_o)
    begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT)
        abort_run("io_cmd_ready_o stayed high with the queue and ids full");
    end
  endtask

  initial
  begin
    void'($urandom(SEED));
    rst_n_i           = 1'b0;
    my_x_i            = 7'd3;
    my_y_i            = 7'd5;
    io_cmd_v_i        = 1'b0;
    io_cmd_msg_type_i = e_msg_rd;
    io_cmd_size_i     = e_size_4;
    io_cmd_addr_i     = '0;
    io_cmd_data_i     = '0;
    out_ready_i       = 1'b0;
    io_resp_yumi_i    = 1'b0;
    bp_en             = 1'b1;
    hold_returns      = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;

    // vcache in pod zero, then the host fallback
    cmd               = random_cmd(REGION_VCACHE);
    cmd.addr[27:25]   = 3'd0;
    send_cmd(cmd);
    send_cmd(random_cmd(2'b01));
    send_cmd(random_cmd(2'b00));
    // every size as a store and as a load
    for (int s = 0; s < 3; s++)
    begin
      cmd          = random_cmd(REGION_TILE);
      cmd.msg_type = e_msg_wr;
      cmd.size     = msg_size_e'(s);
      send_cmd(cmd);
      cmd.msg_type = e_msg_rd;
      send_cmd(cmd);
    end
    for (int i = 0; i < 30; i++)
      send_cmd(random_cmd(2'($urandom)));
    wait_drain();

    // fill every id and the whole queue while returns are held back
    hold_returns = 1'b1;
    bp_en        = 1'b0;
    for (int i = 0; i < MAX_OUTSTANDING + CMD_FIFO_DEPTH; i++)
      send_cmd(random_cmd(2'($urandom)));
    wait_cmd_blocked();
    hold_returns = 1'b0;
    bp_en        = 1'b1;
    wait_drain();

    if (mc_bridge_top_inst.mc_bridge_assert_inst.fail_count == 0)
    begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
    else
      abort_run("a bound protocol assertion failed");
  end

endmodule

//--- all.f
hdl/mc_bridge_pkg.sv
hdl/bridge_if.sv
hdl/cmd_queue.sv
hdl/packet_encode.sv
hdl/reorder_tracker.sv
hdl/mc_bridge_top.sv
tb/mc_net_model.sv
tb/mc_bridge_assert.sv
tb/tb_mc_bridge.sv
